/* hw/vsaPkg.sv */
/*
 * Shared definitions for the Very Simple Architecture core and its system.
 * Widths, payload types, opcode and function encodings and the FSM states.
 * Modules import this package inside their bodies and use scoped names in port lists.
 */

package vsaPkg;

    localparam int wordWidth   = 5;   // data path width
    localparam int addrWidth   = 5;   // pc and memory address width
    localparam int instrWidth  = 12;  // instruction word width
    localparam int regIdxWidth = 2;   // four architectural registers
    localparam int memDepth    = 32;  // entries per memory

    typedef logic [wordWidth-1:0]   wordT;
    typedef logic [addrWidth-1:0]   addrT;
    typedef logic [instrWidth-1:0]  instrT;
    typedef logic [regIdxWidth-1:0] regIdxT;

    // major opcode, IR[11:9]; codes 6 and 7 are unused
    typedef enum logic [2:0] {
        LW    = 3'd0,
        SW    = 3'd1,
        BEQZ  = 3'd2,
        ALUop = 3'd3,  // register-register group, function in IR[2:0]
        ADDI  = 3'd4,
        SUBI  = 3'd5
    } opcodeT;

    // function field of the register-register group
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        NOT = 3'd5,  // operates on A only
        SRL = 3'd6,
        SRA = 3'd7
    } funcT;

    // one state per cycle, five cycles per instruction
    typedef enum logic [2:0] {
        IF  = 3'd0,
        ID  = 3'd1,
        EX  = 3'd2,
        MEM = 3'd3,
        WB  = 3'd4
    } stateT;

endpackage

/* hw/vsaRegisterFile.sv */
/*
 * Four-entry register file of the core, two combinational read ports.
 * R0 is hard-wired to zero and drops writes, R1 to R3 are real storage.
 */

`timescale 1ns/1ps

module vsaRegisterFile (
    input  logic           clock,
    input  logic           arstN,
    input  vsaPkg::regIdxT readIdxA,
    input  vsaPkg::regIdxT readIdxB,
    output vsaPkg::wordT   readA,
    output vsaPkg::wordT   readB,
    input  logic           writeEnable,
    input  vsaPkg::regIdxT writeIdx,
    input  vsaPkg::wordT   writeData
);
    import vsaPkg::*;

    wordT regs [1:3];  // no storage behind R0

    // R0 reads as zero
    assign readA = (readIdxA == '0) ? '0 : regs[readIdxA];
    assign readB = (readIdxB == '0) ? '0 : regs[readIdxB];

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i <= 3; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeIdx != '0)) begin
            regs[writeIdx] <= writeData;  // write to R0 is lost
        end
    end

endmodule

/* hw/vsaAlu.sv */
/*
 * Execute-stage ALU of the core, purely combinational.
 * Gives the result that the core latches into ALUOutput, plus the BEQZ zero test.
 */

`timescale 1ns/1ps

module vsaAlu (
    input  vsaPkg::opcodeT opcode,
    input  vsaPkg::funcT   func,
    input  vsaPkg::wordT   operandA,
    input  vsaPkg::wordT   operandB,
    input  vsaPkg::wordT   immediate,
    input  vsaPkg::addrT   nextPc,
    output vsaPkg::wordT   result,
    output logic           isZero
);
    import vsaPkg::*;

    // branch offset counts instructions, so low four bits times two
    addrT branchTarget;

    assign branchTarget = nextPc + {immediate[3:0], 1'b0};
    assign isZero       = (operandA == '0);  // BEQZ condition on A

    always_comb begin
        result = '0;  // unused opcodes
        case (opcode)
            LW, SW: result = operandA + immediate;  // effective address
            ADDI:   result = operandA + immediate;
            SUBI:   result = operandA - immediate;
            BEQZ:   result = branchTarget;  // pc taken only if A is zero
            ALUop: begin
                case (func)
                    ADD: result = operandA + operandB;  // wraps at 5 bits
                    SUB: result = operandA - operandB;
                    AND: result = operandA & operandB;
                    OR:  result = operandA | operandB;
                    XOR: result = operandA ^ operandB;
                    NOT: result = ~operandA;
                    SRL: result = {1'b0, operandA[4:1]};         // zero fill
                    SRA: result = {operandA[4], operandA[4:1]};  // sign kept
                    default: result = '0;
                endcase
            end
            default: result = '0;
        endcase
    end

endmodule

/* hw/wordMemory.sv */
/*
 * Small memory with asynchronous read and write on the rising clock edge.
 * The word type is a type parameter, so one block serves instructions and data.
 */

`timescale 1ns/1ps

module wordMemory #(
    parameter type memWordT = vsaPkg::wordT
) (
    input  logic         clock,
    input  vsaPkg::addrT readAddr,
    output memWordT      readData,
    input  logic         writeEnable,
    input  vsaPkg::addrT writeAddr,
    input  memWordT      writeData
);
    import vsaPkg::*;

    memWordT mem [memDepth];  // contents survive reset

    // same-cycle read
    assign readData = mem[readAddr];

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            mem[writeAddr] <= writeData;
        end
    end

endmodule

/* hw/vsaCore.sv */
/*
 * Multicycle VSA core with five states per instruction (IF, ID, EX, MEM, WB).
 * Holds the FSM and the datapath registers PC, NPC, IR, A, B, ALUOutput, Cond, LMD.
 * run is looked at only in IF; while it is low the core waits there.
 * Instruction and data memories must answer in the same cycle.
 */

`timescale 1ns/1ps

module vsaCore (
    input  logic          clock,
    input  logic          arstN,
    input  logic          run,
    output vsaPkg::addrT  pc,           // instruction memory address
    input  vsaPkg::instrT instruction,  // same-cycle fetch data
    output vsaPkg::addrT  dataAddr,     // data memory address
    input  vsaPkg::wordT  dataIn,       // load data
    output vsaPkg::wordT  dataOut,      // store data
    output logic          wr            // store strobe for one MEM cycle
);
    import vsaPkg::*;

    stateT state;

    // datapath registers
    addrT  npc;        // pc + 2
    instrT ir;
    wordT  regA;       // first operand
    wordT  regB;       // second operand and store data
    wordT  aluOutput;  // result or address or branch target
    logic  cond;       // BEQZ outcome
    wordT  lmd;        // load data

    // IR fields
    opcodeT opcode;
    regIdxT adFld1;    // source 1
    regIdxT adFld2;    // source 2 or I-format destination
    regIdxT adFld3;    // R-format destination
    funcT   funFld;
    wordT   immFld;

    assign opcode = opcodeT'(ir[11:9]);
    assign adFld1 = ir[8:7];
    assign adFld2 = ir[6:5];
    assign adFld3 = ir[4:3];
    assign funFld = funcT'(ir[2:0]);
    assign immFld = ir[4:0];  // used unsigned

    // instruction classes
    logic memRef;
    logic regRegAlu;
    logic regImmAlu;
    logic branch;
    logic isLoad;

    assign memRef    = (opcode == LW) || (opcode == SW);
    assign regRegAlu = (opcode == ALUop);
    assign regImmAlu = (opcode == ADDI) || (opcode == SUBI);
    assign branch    = (opcode == BEQZ);
    assign isLoad    = (opcode == LW);

    // register file hookup
    wordT   readA;
    wordT   readB;
    logic   rfWrite;
    regIdxT rfWriteIdx;
    wordT   rfWriteData;

    // writes land at the edge that ends WB
    assign rfWrite     = (state == WB) && (regRegAlu || regImmAlu || isLoad);
    assign rfWriteIdx  = regRegAlu ? adFld3 : adFld2;
    assign rfWriteData = isLoad ? lmd : aluOutput;

    vsaRegisterFile registerFile (
        .clock       (clock),
        .arstN       (arstN),
        .readIdxA    (adFld1),
        .readIdxB    (adFld2),
        .readA       (readA),
        .readB       (readB),
        .writeEnable (rfWrite),
        .writeIdx    (rfWriteIdx),
        .writeData   (rfWriteData)
    );

    // ALU sees the registered operands during EX
    wordT aluResult;
    logic aluZero;

    vsaAlu alu (
        .opcode    (opcode),
        .func      (funFld),
        .operandA  (regA),
        .operandB  (regB),
        .immediate (immFld),
        .nextPc    (npc),
        .result    (aluResult),
        .isZero    (aluZero)
    );

    // memory side is plain wiring of the datapath registers
    assign dataAddr = aluOutput;
    assign dataOut  = regB;
    assign wr       = (state == MEM) && (opcode == SW);

    // FSM steps a fixed sequence once run lets IF go
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state <= IF;
        end else begin
            case (state)
                IF:      if (run) state <= ID;  // hold in fetch
                ID:      state <= EX;
                EX:      state <= MEM;
                MEM:     state <= WB;
                WB:      state <= IF;
                default: state <= IF;
            endcase
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc        <= '0;
            npc       <= '0;
            ir        <= '0;
            regA      <= '0;
            regB      <= '0;
            aluOutput <= '0;
            cond      <= 1'b0;
            lmd       <= '0;
        end else begin
            case (state)
                IF: begin
                    if (run) begin
                        npc <= pc + addrT'(2);
                        ir  <= instruction;
                    end
                end
                ID: begin
                    regA <= readA;
                    regB <= readB;
                end
                EX: begin
                    // unused opcodes leave ALUOutput alone
                    if (memRef || regRegAlu || regImmAlu || branch)
                        aluOutput <= aluResult;
                    if (branch)
                        cond <= aluZero;
                end
                MEM: begin
                    if (isLoad)
                        lmd <= dataIn;
                    pc <= (branch && cond) ? aluOutput : npc;  // once per instr
                end
                default: ;  // WB only writes the register file
            endcase
        end
    end

endmodule

/* hw/vsaSystem.sv */
/*
 * System top: VSA core with its instruction memory and data memory.
 * The host fills instruction memory through the load port while run is low.
 * pc and the store port are visible outside so that results can be observed.
 */

`timescale 1ns/1ps

module vsaSystem (
    input  logic          clock,
    input  logic          arstN,
    input  logic          run,
    input  logic          loadWrite,  // host write strobe for program
    input  vsaPkg::addrT  loadAddr,
    input  vsaPkg::instrT loadInstr,
    output vsaPkg::addrT  pc,
    output vsaPkg::addrT  dataAddr,
    output vsaPkg::wordT  dataOut,
    output logic          wr
);
    import vsaPkg::*;

    instrT instruction;  // fetch data back to the core
    wordT  dataIn;       // load data back to the core

    vsaCore core (
        .clock       (clock),
        .arstN       (arstN),
        .run         (run),
        .pc          (pc),
        .instruction (instruction),
        .dataAddr    (dataAddr),
        .dataIn      (dataIn),
        .dataOut     (dataOut),
        .wr          (wr)
    );

    // program store, core reads and host writes
    wordMemory #(
        .memWordT (instrT)
    ) instrMemory (
        .clock       (clock),
        .readAddr    (pc),
        .readData    (instruction),
        .writeEnable (loadWrite),
        .writeAddr   (loadAddr),
        .writeData   (loadInstr)
    );

    // data store, one address for loads and stores
    wordMemory #(
        .memWordT (wordT)
    ) dataMemory (
        .clock       (clock),
        .readAddr    (dataAddr),
        .readData    (dataIn),
        .writeEnable (wr),
        .writeAddr   (dataAddr),
        .writeData   (dataOut)
    );

endmodule

/* bench/vsaSystemTb.sv */
/*
 * Testbench for the VSA system. Reads the cases from bench/vsaTests.txt,
 * loads each program through the host port while run is low, runs it and
 * checks every store, the wr timing, the pc steps and the final pc.
 */

`timescale 1ns/1ps

module vsaSystemTb;
    import vsaPkg::*;

    localparam int periodNs     = 100;
    localparam int resetCycles  = 16;
    localparam int holdCycles   = 4;   // run low after reset
    localparam int marginCycles = 50;
    localparam int maxTestWords = 512;

    logic  clock;
    logic  arstN;
    logic  run;
    logic  loadWrite;
    addrT  loadAddr;
    instrT loadInstr;
    addrT  pc;
    addrT  dataAddr;
    wordT  dataOut;
    logic  wr;

    // parsed test cases in flat queues indexed per case
    logic [11:0] testWords [maxTestWords];
    addrT  progAddrQ[$];
    instrT progInstrQ[$];
    addrT  storeAddrQ[$];
    wordT  storeDataQ[$];
    int    progFirstQ[$];
    int    progLenQ[$];
    int    storeFirstQ[$];
    int    storeLenQ[$];
    int    instrCountQ[$];
    addrT  finalPcQ[$];

    bit     testsReady;
    longint watchdogCycles;

    vsaSystem UUT (
        .clock     (clock),
        .arstN     (arstN),
        .run       (run),
        .loadWrite (loadWrite),
        .loadAddr  (loadAddr),
        .loadInstr (loadInstr),
        .pc        (pc),
        .dataAddr  (dataAddr),
        .dataOut   (dataOut),
        .wr        (wr)
    );

    initial begin
        clock = 1'b0;
        forever #(periodNs / 2) clock = ~clock;
    end

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compareWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected)
            stopWithFailure($sformatf("mismatch at %0t: %s expected %h actual %h",
                                      $time, name, expected, actual));
    endtask

    task automatic compareAddr(input string name, input addrT expected, input addrT actual);
        if (actual !== expected)
            stopWithFailure($sformatf("mismatch at %0t: %s expected %h actual %h",
                                      $time, name, expected, actual));
    endtask

    task automatic readTests();
        int          p;
        int          progStart;
        int          storeStart;
        bit          done;
        logic [11:0] kind;
        $readmemh("bench/vsaTests.txt", testWords);
        p          = 0;
        progStart  = 0;
        storeStart = 0;
        done       = 1'b0;
        while (!done) begin
            if (p > maxTestWords - 3)
                stopWithFailure("tests file has no end record");
            kind = testWords[p];
            case (kind)
                12'h0: done = 1'b1;
                12'h1: begin
                    progAddrQ.push_back(addrT'(testWords[p+1]));
                    progInstrQ.push_back(instrT'(testWords[p+2]));
                    p += 3;
                end
                12'h2: begin
                    instrCountQ.push_back(int'(testWords[p+1]));
                    p += 2;
                end
                12'h3: begin
                    storeAddrQ.push_back(addrT'(testWords[p+1]));
                    storeDataQ.push_back(wordT'(testWords[p+2]));
                    p += 3;
                end
                12'h4: begin  // closes the case
                    finalPcQ.push_back(addrT'(testWords[p+1]));
                    progFirstQ.push_back(progStart);
                    progLenQ.push_back(progAddrQ.size() - progStart);
                    storeFirstQ.push_back(storeStart);
                    storeLenQ.push_back(storeAddrQ.size() - storeStart);
                    progStart  = progAddrQ.size();
                    storeStart = storeAddrQ.size();
                    p += 2;
                end
                default: stopWithFailure($sformatf("tests file has a bad record at word %0d", p));
            endcase
        end
        if (instrCountQ.size() != finalPcQ.size())
            stopWithFailure("tests file has a case without an instruction count");
    endtask

    // core must sit still while run is low
    task automatic checkIdle();
        compareAddr("pc", addrT'(0), pc);
        if (wr !== 1'b0)
            stopWithFailure($sformatf("wr went high at %0t while run was low", $time));
    endtask

    task automatic applyReset();
        @(negedge clock);
        arstN = 1'b0;
        run   = 1'b0;
        repeat (resetCycles) @(negedge clock);
    endtask

    task automatic loadProgram(input int c);
        for (int k = progFirstQ[c]; k < progFirstQ[c] + progLenQ[c]; k++) begin
            loadWrite = 1'b1;
            loadAddr  = progAddrQ[k];
            loadInstr = progInstrQ[k];
            @(negedge clock);  // written at the rising edge in between
            checkIdle();
        end
        loadWrite = 1'b0;
    endtask

    task automatic runCase(input int c);
        addrT pcStart;
        addrT lastPc;
        int   storeIdx;
        int   storeEnd;
        storeIdx = storeFirstQ[c];
        storeEnd = storeFirstQ[c] + storeLenQ[c];
        lastPc   = '0;
        applyReset();
        arstN = 1'b1;  // core out of reset and held by run during the load
        loadProgram(c);
        repeat (holdCycles) begin
            @(negedge clock);
            checkIdle();
        end
        run = 1'b1;
        for (int i = 0; i < instrCountQ[c]; i++) begin
            // s follows the state IF ID EX MEM WB
            for (int s = 0; s < 5; s++) begin
                if (i > 0 || s > 0)
                    @(negedge clock);
                if (s == 0) begin
                    compareAddr("pc", lastPc, pc);  // no change between instructions
                    pcStart = pc;
                end else if (s < 4) begin
                    compareAddr("pc", pcStart, pc);
                end else begin
                    if (pc === pcStart)
                        stopWithFailure($sformatf("pc did not step at %0t", $time));
                    lastPc = pc;
                end
                if (wr === 1'b1) begin
                    if (s != 3)
                        stopWithFailure($sformatf("wr high outside MEM at %0t", $time));
                    else if (storeIdx == storeEnd)
                        stopWithFailure($sformatf("unexpected store to address %h at %0t",
                                                  dataAddr, $time));
                    compareAddr("dataAddr", storeAddrQ[storeIdx], dataAddr);
                    compareWord("dataOut", storeDataQ[storeIdx], dataOut);
                    storeIdx++;
                end else if (wr !== 1'b0) begin
                    stopWithFailure($sformatf("wr is unknown at %0t", $time));
                end
            end
        end
        run = 1'b0;  // core parks in IF after the last WB
        compareAddr("final pc", finalPcQ[c], pc);
        if (storeIdx != storeEnd)
            stopWithFailure($sformatf("case %0d is missing %0d expected stores",
                                      c, storeEnd - storeIdx));
    endtask

    initial begin : watchdog
        wait (testsReady);
        #(watchdogCycles * periodNs);
        stopWithFailure("timeout, the tests did not finish in time");
    end

    initial begin
        longint cycles;
        arstN      = 1'b0;
        run        = 1'b0;
        loadWrite  = 1'b0;
        loadAddr   = '0;
        loadInstr  = '0;
        testsReady = 1'b0;
        readTests();
        cycles = marginCycles;
        for (int c = 0; c < finalPcQ.size(); c++)
            cycles += 1 + resetCycles + progLenQ[c] + holdCycles + 5 * instrCountQ[c];
        watchdogCycles = cycles;
        testsReady     = 1'b1;
        for (int c = 0; c < finalPcQ.size(); c++)
            runCase(c);
        @(negedge clock);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* bench/vsaTests.txt */
// records in hex: 1 addr instr = program word, 2 n = instructions to run,
// 3 addr data = expected store in order, 4 pc = expected final pc and end of case, 0 = end
// ALU group one: R1 = 13, R2 = 22, then ADD SUB AND OR into R3
1 00 82D  1 02 856  1 04 6D8  1 06 261  1 08 6D9
1 0A 262  1 0C 6DA  1 0E 263  1 10 6DB  1 12 264
2 0A  3 01 03  3 02 17  3 03 04  3 04 1F  4 14
// ALU group two: XOR, NOT of R1, SRL and SRA of R2
1 00 82D  1 02 856  1 04 6DC  1 06 265  1 08 6DD
1 0A 266  1 0C 71E  1 0E 267  1 10 71F  1 12 268
2 0A  3 05 1B  3 06 12  3 07 0B  3 08 1B  4 14
// ADDI and SUBI with wrap, write to R0 is lost
1 00 829  1 02 AC3  1 04 A61  1 06 885  1 08 22A
1 0A 24B  1 0C 26C  1 0E 20D  1 10 8BF  1 12 22E
2 0A  3 0A 09  3 0B 06  3 0C 1F  3 0D 00  3 0E 08  4 14
// SW then LW round trip, address wraps at 32
1 00 834  1 02 853  1 04 2C3  1 06 0E3  1 08 264  1 0A 2EF
2 06  3 17 13  3 04 13  3 03 13  4 0C
// BEQZ taken, not taken, taken with imm bit 4 ignored
1 00 821  1 02 402  1 04 230  1 06 231  1 08 483  1 0A 232
1 0C 413  1 0E 233  1 10 234  1 12 235  1 14 236
2 06  3 12 01  3 16 01  4 16
0

/* project.f */
hw/vsaPkg.sv
hw/vsaRegisterFile.sv
hw/vsaAlu.sv
hw/wordMemory.sv
hw/vsaCore.sv
hw/vsaSystem.sv
bench/vsaSystemTb.sv

/* Bender.yml */
package:
  name: vsa_system

sources:
  - files:
      - hw/vsaPkg.sv
      - hw/vsaRegisterFile.sv
      - hw/vsaAlu.sv
      - hw/wordMemory.sv
      - hw/vsaCore.sv
      - hw/vsaSystem.sv
  - target: simulation
    files:
      - bench/vsaSystemTb.sv
